// ==== logic/fetch_params.svh ====
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

////////////////////////////////////////
// Operand fetch dimensions
////////////////////////////////////////

// Width of one data word.
`define FETCH_DATA_WIDTH 16

// Channels in the channel file.
`define FETCH_N_CHANNELS 16

// Commit ids wrap around, so this only has to cover the writes in flight.
`define FETCH_COMMIT_ID_WIDTH 8

// Width of each per-channel pending write counter.
`define FETCH_PENDING_WIDTH 4

// Width of the operation code.
`define FETCH_OPERATION_WIDTH 5

`endif

// ==== logic/isa_pkg.sv ====
`include "fetch_params.svh"

package isa_pkg;

	////////////////////////////////////////
	// Words and fields
	////////////////////////////////////////

	typedef logic signed [`FETCH_DATA_WIDTH - 1 : 0] data_t;

	typedef logic [$clog2(`FETCH_N_CHANNELS) - 1 : 0] chan_addr_t;

	typedef logic [`FETCH_OPERATION_WIDTH - 1 : 0] operation_t;

	////////////////////////////////////////
	// Operand source
	////////////////////////////////////////

	// With from_reg clear, src is a channel index.
	// With from_reg set, src 0 and 1 pick register_0 and register_1,
	// src 3 and 4 pick the two fixed constants and anything else gives zero.
	// An operand that is not needed reads as zero.
	typedef struct packed {
		logic needed;
		logic from_reg;
		chan_addr_t src;
	} operand_sel_t;

endpackage

// ==== logic/pipe_pkg.sv ====
`include "fetch_params.svh"

package pipe_pkg;
	import isa_pkg::*;

	typedef logic [`FETCH_COMMIT_ID_WIDTH - 1 : 0] commit_id_t;

	typedef logic [`FETCH_PENDING_WIDTH - 1 : 0] pending_t;

	////////////////////////////////////////
	// Instruction payloads
	////////////////////////////////////////

	// Index 0 of sel is operand a, 1 is b and 2 is c.
	typedef struct packed {
		operation_t operation;
		chan_addr_t dest;
		logic writes_channel;
		data_t register_0;
		data_t register_1;
		operand_sel_t [2 : 0] sel;
	} instr_t;

	// Args use the same indexing as sel.
	typedef struct packed {
		instr_t instr;
		commit_id_t commit_id;
		data_t [2 : 0] args;
	} flight_t;

	typedef struct packed {
		operation_t operation;
		chan_addr_t dest;
		logic writes_channel;
		commit_id_t commit_id;
		data_t arg_a;
		data_t arg_b;
		data_t arg_c;
	} issued_t;

	////////////////////////////////////////
	// Channel file traffic
	////////////////////////////////////////

	typedef struct packed {
		logic valid;
		chan_addr_t addr;
		data_t value;
	} write_back_t;

	typedef struct packed {
		logic valid;
		chan_addr_t addr;
	} claim_t;

	// The commit id places the reader in program order among the writers.
	typedef struct packed {
		chan_addr_t addr;
		commit_id_t commit_id;
	} read_req_t;

	typedef struct packed {
		logic ready;
		data_t value;
	} read_resp_t;

	typedef enum logic {
		slot_idle,
		slot_wait
	} slot_state_t;

endpackage

// ==== logic/instr_intake.sv ====
module instr_intake import pipe_pkg::*; (
	input logic clk,
	input logic reset,
	input logic in_valid,
	output logic in_ready,
	input instr_t instr,
	output logic out_valid,
	input logic out_ready,
	output flight_t flight,
	output claim_t claim
);
	commit_id_t next_id;
	logic take_in;

	assign in_ready = ~out_valid | out_ready;
	assign take_in = in_valid & in_ready;

	// The claim lands in the scoreboard on the same edge that accepts the instruction.
	assign claim.valid = take_in & instr.writes_channel;
	assign claim.addr = instr.dest;

	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
			next_id <= '0;
		end else begin
			if (take_in) begin
				out_valid <= 1'b1;
			end else if (out_ready) begin
				out_valid <= 1'b0;
			end
			if (claim.valid) begin
				next_id <= next_id + 1'b1;
			end
		end
	end

	// Instructions that do not write a channel still carry the next id.
	// It marks how many writers are ahead of them.
	always_ff @(posedge clk) begin
		if (take_in) begin
			flight.instr <= instr;
			flight.commit_id <= next_id;
			flight.args <= '0;
		end
	end

endmodule

// ==== logic/channel_file.sv ====
`include "fetch_params.svh"

module channel_file import isa_pkg::*, pipe_pkg::*; (
	input logic clk,
	input logic reset,
	input claim_t claim,
	input write_back_t write_back,
	input read_req_t read_req [3],
	output read_resp_t read_resp [3]
);
	data_t channels [`FETCH_N_CHANNELS];
	pending_t pending [`FETCH_N_CHANNELS];

	// Write-backs come back in commit order, so this is the id of the next one.
	commit_id_t completed;

	logic [`FETCH_N_CHANNELS - 1 : 0] claim_hit;
	logic [`FETCH_N_CHANNELS - 1 : 0] release_hit;

	////////////////////////////////////////
	// Scoreboard and channel registers
	////////////////////////////////////////

	always_comb begin
		for (int i = 0; i < `FETCH_N_CHANNELS; i++) begin
			claim_hit[i] = claim.valid && claim.addr == chan_addr_t'(i);
			release_hit[i] = write_back.valid && write_back.addr == chan_addr_t'(i)
				&& pending[i] != '0;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `FETCH_N_CHANNELS; i++) begin
				channels[i] <= '0;
				pending[i] <= '0;
			end
			completed <= '0;
		end else begin
			if (write_back.valid) begin
				channels[write_back.addr] <= write_back.value;
				completed <= completed + 1'b1;
			end
			// A claim and a release on one channel cancel out.
			for (int i = 0; i < `FETCH_N_CHANNELS; i++) begin
				case ({claim_hit[i], release_hit[i]})
					2'b10: pending[i] <= pending[i] + 1'b1;
					2'b01: pending[i] <= pending[i] - 1'b1;
					default: pending[i] <= pending[i];
				endcase
			end
		end
	end

	////////////////////////////////////////
	// Read ports
	////////////////////////////////////////

	// Pending writes may belong to younger instructions, which cannot write back
	// before this reader leaves. Once every older write is done, the stored value holds.
	always_comb begin
		chan_addr_t addr;
		pending_t count;
		logic wb_hit;
		logic older_done;
		logic last_arriving;

		for (int p = 0; p < 3; p++) begin
			addr = read_req[p].addr;
			count = pending[addr];
			wb_hit = write_back.valid && write_back.addr == addr;
			older_done = completed == read_req[p].commit_id;
			last_arriving = write_back.valid && completed + 1'b1 == read_req[p].commit_id;

			read_resp[p].ready = 1'b0;
			read_resp[p].value = channels[addr];
			if (count == '0) begin
				read_resp[p].ready = 1'b1;
			end else if (wb_hit && (count == pending_t'(1) || last_arriving)) begin
				read_resp[p].ready = 1'b1;
				read_resp[p].value = write_back.value;
			end else if (older_done || last_arriving) begin
				read_resp[p].ready = 1'b1;
			end
		end
	end

endmodule

// ==== logic/operand_fetch_slot.sv ====
`include "fetch_params.svh"

module operand_fetch_slot import isa_pkg::*, pipe_pkg::*; #(
	parameter int operand_index = 0
) (
	input logic clk,
	input logic reset,
	input logic in_valid,
	output logic in_ready,
	input flight_t flight_in,
	output logic out_valid,
	input logic out_ready,
	output flight_t flight_out,
	output read_req_t read_req,
	input read_resp_t read_resp
);
	slot_state_t state;
	flight_t held;

	operand_sel_t sel_in;
	operand_sel_t sel_held;
	logic local_in;
	logic entry_ready;
	data_t entry_value;
	flight_t filled_in;
	flight_t filled_held;
	logic out_free;
	logic take_in;
	logic emit_wait;

	// Value of an operand that needs no channel read.
	function automatic data_t local_operand(operand_sel_t sel, data_t register_0,
			data_t register_1);
		data_t value;

		value = '0;
		if (sel.needed) begin
			case (sel.src)
				0: value = register_0;
				1: value = register_1;
				3: value = data_t'(1) << (`FETCH_DATA_WIDTH - 2);
				4: value = data_t'(1) << (`FETCH_DATA_WIDTH - 1);
				default: value = '0;
			endcase
		end
		return value;
	endfunction

	assign sel_in = flight_in.instr.sel[operand_index];
	assign sel_held = held.instr.sel[operand_index];
	assign local_in = ~sel_in.needed | sel_in.from_reg;

	assign read_req.addr = (state == slot_wait) ? sel_held.src : sel_in.src;
	assign read_req.commit_id = (state == slot_wait) ? held.commit_id : flight_in.commit_id;

	assign out_free = ~out_valid | out_ready;
	assign in_ready = (state == slot_idle) & out_free;
	assign take_in = in_valid & in_ready;

	assign entry_ready = local_in | read_resp.ready;
	assign emit_wait = (state == slot_wait) & out_free & read_resp.ready;

	always_comb begin
		entry_value = read_resp.value;
		if (local_in) begin
			entry_value = local_operand(sel_in, flight_in.instr.register_0,
				flight_in.instr.register_1);
		end
		filled_in = flight_in;
		filled_in.args[operand_index] = entry_value;
		filled_held = held;
		filled_held.args[operand_index] = read_resp.value;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= slot_idle;
			out_valid <= 1'b0;
		end else begin
			if ((take_in & entry_ready) | emit_wait) begin
				out_valid <= 1'b1;
			end else if (out_ready) begin
				out_valid <= 1'b0;
			end
			if (take_in & ~entry_ready) begin
				state <= slot_wait;
			end else if (emit_wait) begin
				state <= slot_idle;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (take_in & entry_ready) begin
			flight_out <= filled_in;
		end else if (emit_wait) begin
			flight_out <= filled_held;
		end
		if (take_in & ~entry_ready) begin
			held <= flight_in;
		end
	end

endmodule

// ==== logic/skid_buffer.sv ====
module skid_buffer import pipe_pkg::*; #(
	parameter type payload_t = issued_t
) (
	input logic clk,
	input logic reset,
	input logic in_valid,
	output logic in_ready,
	input payload_t payload_in,
	output logic out_valid,
	input logic out_ready,
	output payload_t payload_out
);
	logic main_valid;
	logic skid_valid;
	payload_t main_q;
	payload_t skid_q;
	logic take_in;
	logic take_out;

	// While the main register is empty the input goes straight through.
	assign out_valid = main_valid | in_valid;
	assign payload_out = main_valid ? main_q : payload_in;

	assign in_ready = ~skid_valid;
	assign take_in = in_valid & in_ready;
	assign take_out = out_valid & out_ready;

	always_ff @(posedge clk) begin
		if (reset) begin
			main_valid <= 1'b0;
			skid_valid <= 1'b0;
		end else if (!main_valid) begin
			main_valid <= take_in & ~out_ready;
		end else if (!skid_valid) begin
			if (take_out) begin
				main_valid <= take_in;
			end else begin
				skid_valid <= take_in;
			end
		end else if (take_out) begin
			skid_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (~main_valid | (take_out & ~skid_valid)) begin
			main_q <= payload_in;
		end else if (take_out) begin
			main_q <= skid_q;
		end
		if (~skid_valid) begin
			skid_q <= payload_in;
		end
	end

endmodule

// ==== logic/operand_fetch_stage.sv ====
module operand_fetch_stage import pipe_pkg::*; (
	input logic clk,
	input logic reset,
	input logic in_valid,
	output logic in_ready,
	input instr_t instr,
	output logic out_valid,
	input logic out_ready,
	output issued_t issued,
	input write_back_t write_back
);
	// Link 0 leaves the intake, link n + 1 leaves slot n.
	logic link_valid [4];
	logic link_ready [4];
	flight_t link_flight [4];

	claim_t claim;
	read_req_t read_req [3];
	read_resp_t read_resp [3];
	issued_t slot_issued;

	instr_intake u_intake (
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.instr(instr),
		.out_valid(link_valid[0]),
		.out_ready(link_ready[0]),
		.flight(link_flight[0]),
		.claim(claim)
	);

	channel_file u_channels (
		.clk(clk),
		.reset(reset),
		.claim(claim),
		.write_back(write_back),
		.read_req(read_req),
		.read_resp(read_resp)
	);

	for (genvar i = 0; i < 3; i++) begin : g_slot
		operand_fetch_slot #(.operand_index(i)) u_slot (
			.clk(clk),
			.reset(reset),
			.in_valid(link_valid[i]),
			.in_ready(link_ready[i]),
			.flight_in(link_flight[i]),
			.out_valid(link_valid[i + 1]),
			.out_ready(link_ready[i + 1]),
			.flight_out(link_flight[i + 1]),
			.read_req(read_req[i]),
			.read_resp(read_resp[i])
		);
	end

	always_comb begin
		slot_issued.operation = link_flight[3].instr.operation;
		slot_issued.dest = link_flight[3].instr.dest;
		slot_issued.writes_channel = link_flight[3].instr.writes_channel;
		slot_issued.commit_id = link_flight[3].commit_id;
		slot_issued.arg_a = link_flight[3].args[0];
		slot_issued.arg_b = link_flight[3].args[1];
		slot_issued.arg_c = link_flight[3].args[2];
	end

	skid_buffer #(.payload_t(issued_t)) u_skid (
		.clk(clk),
		.reset(reset),
		.in_valid(link_valid[3]),
		.in_ready(link_ready[3]),
		.payload_in(slot_issued),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.payload_out(issued)
	);

endmodule

// ==== tests/operand_fetch_tb.sv ====
`include "fetch_params.svh"

module operand_fetch_tb import isa_pkg::*, pipe_pkg::*; ();

	localparam int n_entries = 24;
	localparam int timeout_cycles = n_entries * 40 + 100;

	logic clk;
	logic reset;
	logic in_valid;
	logic in_ready;
	instr_t instr;
	logic out_valid;
	logic out_ready;
	issued_t issued;
	write_back_t write_back;

	instr_t table_instr [n_entries];
	data_t table_result [n_entries];
	data_t expected_args [n_entries][3];
	commit_id_t expected_commit [n_entries];
	int accept_cycle [n_entries];
	int first_valid_cycle [n_entries];
	int n_loaded;

	// Pending write-backs of the executor, oldest first.
	write_back_t wb_queue [$];
	int wb_due [$];

	int cycles;
	int out_count;
	logic random_ready;
	integer seed;

	operand_fetch_stage dut (
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.instr(instr),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.issued(issued),
		.write_back(write_back)
	);

	always #10 clk = ~clk;

	////////////////////////////////////////
	// Reporting
	////////////////////////////////////////

	task automatic stop_failed();
		$display("Some tests failed");
		$fatal(1);
	endtask

	task automatic check_data(string name, data_t expected, data_t actual);
		if (actual !== expected) begin
			$display("error at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
			stop_failed();
		end
	endtask

	task automatic check_commit(string name, commit_id_t expected, commit_id_t actual);
		if (actual !== expected) begin
			$display("error at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
			stop_failed();
		end
	endtask

	task automatic check_operation(string name, operation_t expected, operation_t actual);
		if (actual !== expected) begin
			$display("error at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
			stop_failed();
		end
	endtask

	task automatic check_addr(string name, chan_addr_t expected, chan_addr_t actual);
		if (actual !== expected) begin
			$display("error at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
			stop_failed();
		end
	endtask

	task automatic check_flag(string name, logic expected, logic actual);
		if (actual !== expected) begin
			$display("error at %0t: %s expected %b, got %b", $time, name, expected, actual);
			stop_failed();
		end
	endtask

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= timeout_cycles) begin
			$display("The run timed out after %0d cycles", cycles);
			stop_failed();
		end
	end

	////////////////////////////////////////
	// Instruction table
	////////////////////////////////////////

	function automatic operand_sel_t chan_sel(int addr);
		return '{needed: 1'b1, from_reg: 1'b0, src: chan_addr_t'(addr)};
	endfunction

	function automatic operand_sel_t local_sel(int src);
		return '{needed: 1'b1, from_reg: 1'b1, src: chan_addr_t'(src)};
	endfunction

	function automatic operand_sel_t unused_sel(int src);
		return '{needed: 1'b0, from_reg: 1'b0, src: chan_addr_t'(src)};
	endfunction

	task automatic add_entry(int operation, int dest, logic writes, int r0, int r1,
			operand_sel_t sel_a, operand_sel_t sel_b, operand_sel_t sel_c, int result);
		instr_t entry;

		entry.operation = operation_t'(operation);
		entry.dest = chan_addr_t'(dest);
		entry.writes_channel = writes;
		entry.register_0 = data_t'(r0);
		entry.register_1 = data_t'(r1);
		entry.sel[0] = sel_a;
		entry.sel[1] = sel_b;
		entry.sel[2] = sel_c;
		table_instr[n_loaded] = entry;
		table_result[n_loaded] = data_t'(result);
		n_loaded++;
	endtask

	// Columns are operation, dest, writes, register_0, register_1, a, b, c, result.
	task automatic load_table();
		add_entry(1, 0, 0, 100, -7, local_sel(0), local_sel(1), local_sel(3), 0);
		add_entry(2, 1, 1, 5, 6, local_sel(4), unused_sel(2), local_sel(0), 111);
		add_entry(3, 2, 1, 0, 0, chan_sel(1), chan_sel(0), unused_sel(1), 222);
		add_entry(4, 1, 1, 0, 9, chan_sel(2), chan_sel(1), local_sel(1), -50);
		add_entry(5, 3, 0, 0, 0, chan_sel(1), unused_sel(1), chan_sel(2), 0);
		add_entry(6, 4, 1, 0, 0, chan_sel(3), local_sel(7), chan_sel(1), 1234);
		add_entry(7, 4, 1, 0, 0, chan_sel(4), chan_sel(4), chan_sel(4), 77);
		add_entry(8, 5, 0, 0, 0, chan_sel(4), local_sel(3), unused_sel(4), 0);
		add_entry(9, 6, 1, -1, 0, local_sel(0), chan_sel(5), chan_sel(6), 600);
		add_entry(10, 6, 1, 0, 3, chan_sel(6), local_sel(1), unused_sel(6), 601);
		add_entry(11, 7, 0, 0, 0, chan_sel(6), chan_sel(1), chan_sel(2), 0);
		add_entry(12, 8, 1, 0, 0, unused_sel(8), unused_sel(6), chan_sel(8), 800);
		add_entry(13, 9, 1, 0, 0, chan_sel(8), chan_sel(9), local_sel(4), 900);
		add_entry(14, 9, 1, 0, 0, chan_sel(9), chan_sel(8), chan_sel(4), -901);
		add_entry(15, 10, 0, 42, 0, chan_sel(9), local_sel(0), unused_sel(9), 0);
		add_entry(16, 10, 1, 0, 0, chan_sel(10), chan_sel(9), chan_sel(1), 1000);
		add_entry(17, 11, 1, 0, 0, chan_sel(10), chan_sel(10), local_sel(2), 1100);
		add_entry(18, 0, 1, 0, 0, chan_sel(11), chan_sel(0), chan_sel(15), 5);
		add_entry(19, 0, 1, 0, 0, chan_sel(0), chan_sel(0), chan_sel(11), 6);
		add_entry(20, 12, 0, 0, -3, chan_sel(0), local_sel(1), local_sel(4), 0);
		add_entry(21, 13, 1, 0, 0, chan_sel(12), chan_sel(0), chan_sel(2), 1300);
		add_entry(22, 13, 1, 0, 0, chan_sel(13), unused_sel(13), chan_sel(13), 1301);
		add_entry(23, 14, 1, 0, 0, chan_sel(13), chan_sel(14), chan_sel(6), 1400);
		add_entry(24, 15, 0, 0, 0, chan_sel(14), chan_sel(13), chan_sel(0), 0);
	endtask

	function automatic data_t operand_value(operand_sel_t sel, instr_t entry, data_t chan_value);
		data_t value;

		value = '0;
		if (sel.needed && !sel.from_reg) begin
			value = chan_value;
		end else if (sel.needed) begin
			case (int'(sel.src))
				0: value = entry.register_0;
				1: value = entry.register_1;
				3: value = {2'b01, {(`FETCH_DATA_WIDTH - 2){1'b0}}};
				4: value = {1'b1, {(`FETCH_DATA_WIDTH - 1){1'b0}}};
				default: value = '0;
			endcase
		end
		return value;
	endfunction

	// Walks the table in program order and tracks what each channel holds.
	task automatic build_expected();
		data_t model [`FETCH_N_CHANNELS];
		commit_id_t writers;

		writers = '0;
		for (int c = 0; c < `FETCH_N_CHANNELS; c++) begin
			model[c] = '0;
		end
		for (int i = 0; i < n_entries; i++) begin
			for (int k = 0; k < 3; k++) begin
				expected_args[i][k] = operand_value(table_instr[i].sel[k], table_instr[i],
					model[table_instr[i].sel[k].src]);
			end
			expected_commit[i] = writers;
			if (table_instr[i].writes_channel) begin
				model[table_instr[i].dest] = table_result[i];
				writers = writers + 1'b1;
			end
		end
	endtask

	////////////////////////////////////////
	// Executor and output checks
	////////////////////////////////////////

	task automatic observe_output();
		int i;
		int delay;
		write_back_t wb;

		i = out_count;
		if (out_valid && i >= n_entries) begin
			$display("The DUT issued more records than instructions were sent");
			stop_failed();
		end else if (out_valid) begin
			if (first_valid_cycle[i] < 0) begin
				first_valid_cycle[i] = cycles;
			end
			if (out_ready) begin
				check_operation("issued.operation", table_instr[i].operation, issued.operation);
				check_addr("issued.dest", table_instr[i].dest, issued.dest);
				check_flag("issued.writes_channel", table_instr[i].writes_channel,
					issued.writes_channel);
				check_commit("issued.commit_id", expected_commit[i], issued.commit_id);
				check_data("issued.arg_a", expected_args[i][0], issued.arg_a);
				check_data("issued.arg_b", expected_args[i][1], issued.arg_b);
				check_data("issued.arg_c", expected_args[i][2], issued.arg_c);
				if (table_instr[i].writes_channel) begin
					wb.valid = 1'b1;
					wb.addr = table_instr[i].dest;
					wb.value = table_result[i];
					delay = $unsigned($random(seed)) % 5;
					wb_queue.push_back(wb);
					wb_due.push_back(cycles + 1 + delay);
				end
				out_count++;
			end
		end
	endtask

	always @(negedge clk) begin
		out_ready = random_ready ? (($random(seed) & 1) == 1) : 1'b1;
		write_back = '0;
		if (wb_queue.size() > 0 && wb_due[0] <= cycles) begin
			write_back = wb_queue.pop_front();
			void'(wb_due.pop_front());
		end
		#1;
		observe_output();
	end

	////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////

	task automatic send_instr(int i);
		@(negedge clk);
		in_valid = 1'b1;
		instr = table_instr[i];
		#1;
		while (!in_ready) begin
			@(negedge clk);
			#1;
		end
		accept_cycle[i] = cycles;
		@(posedge clk);
	endtask

	task automatic wait_outputs(int n);
		while (out_count < n) begin
			@(negedge clk);
		end
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		in_valid = 1'b0;
		instr = '0;
		out_ready = 1'b1;
		write_back = '0;
		random_ready = 1'b0;
		seed = 32'hb9;
		cycles = 0;
		out_count = 0;
		n_loaded = 0;
		for (int i = 0; i < n_entries; i++) begin
			first_valid_cycle[i] = -1;
		end
		load_table();
		build_expected();

		repeat (5) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		#1;
		if (out_valid !== 1'b0) begin
			$display("out_valid is not low after reset");
			stop_failed();
		end
		if (in_ready !== 1'b1) begin
			$display("in_ready is not high after reset");
			stop_failed();
		end

		// A lone instruction with local operands sets the base latency.
		send_instr(0);
		@(negedge clk);
		in_valid = 1'b0;
		wait_outputs(1);
		if (first_valid_cycle[0] - accept_cycle[0] != 4) begin
			$display("The first instruction took %0d cycles instead of 4",
				first_valid_cycle[0] - accept_cycle[0]);
			stop_failed();
		end

		for (int i = 1; i < 12; i++) begin
			send_instr(i);
		end
		random_ready = 1'b1;
		for (int i = 12; i < n_entries; i++) begin
			send_instr(i);
		end
		@(negedge clk);
		in_valid = 1'b0;
		instr = '0;
		wait_outputs(n_entries);
		while (wb_queue.size() > 0) begin
			@(negedge clk);
		end
		repeat (2) @(negedge clk);

		$display("All tests passed");
		$finish;
	end

endmodule

// ==== project.f ====
+incdir+logic
logic/isa_pkg.sv
logic/pipe_pkg.sv
logic/instr_intake.sv
logic/channel_file.sv
logic/operand_fetch_slot.sv
logic/skid_buffer.sv
logic/operand_fetch_stage.sv
tests/operand_fetch_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the operand fetch testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing -f project.f --top-module operand_fetch_tb -o operand_fetch_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/operand_fetch_sim > "$log" 2>&1
status=$?
cat "$log"

if grep -q "Some tests failed" "$log"; then
	exit 1
fi
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi
exit 0
